// File: i2c_cmd_pkg.sv
package i2c_cmd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int CMD_W              = 32;
    localparam int BYTE_W             = 8;
    localparam int PHASES_PER_BIT     = 3;
    localparam int BITS_PER_BYTE_SLOT = 9;
    localparam int START_CYCLES       = 3;
    localparam int STOP_CYCLES        = 3;
    localparam int BYTE_IDX_W         = 2;

    // Byte count of each format
    localparam int            BYTE_CNT_W  = 3;
    localparam logic [2:0]    BYTES_REG16 = 3'd4;
    localparam logic [2:0]    BYTES_REG8  = 3'd3;

    // Counter widths inside the engine
    localparam int STEP_CNT_W  = 2;
    localparam int PHASE_CNT_W = 2;
    localparam int BIT_CNT_W   = 4;

    // SCL is high in the middle phase of a bit slot
    localparam logic [PHASE_CNT_W-1:0] SCL_HIGH_PHASE = 2'd1;

    // Frame FSM encoding
    localparam int                  SEQ_ST_W  = 2;
    localparam logic [SEQ_ST_W-1:0] SEQ_IDLE  = 2'd0;
    localparam logic [SEQ_ST_W-1:0] SEQ_START = 2'd1;
    localparam logic [SEQ_ST_W-1:0] SEQ_BYTE  = 2'd2;
    localparam logic [SEQ_ST_W-1:0] SEQ_STOP  = 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // Command word
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        FMT_REG8  = 1'b0,
        FMT_REG16 = 1'b1
    } frame_fmt_e;

    // Device address, 16-bit register, data
    typedef struct packed {
        logic [BYTE_W-1:0] dev_addr;
        logic [BYTE_W-1:0] reg_hi;
        logic [BYTE_W-1:0] reg_lo;
        logic [BYTE_W-1:0] wr_data;
    } reg16_view_t;

    // Top byte not sent in the 8-bit register format
    typedef struct packed {
        logic [BYTE_W-1:0] unused;
        logic [BYTE_W-1:0] dev_addr;
        logic [BYTE_W-1:0] reg_addr;
        logic [BYTE_W-1:0] wr_data;
    } reg8_view_t;

    typedef union packed {
        reg16_view_t reg16;
        reg8_view_t  reg8;
    } cmd_word_u;

endpackage

// File: cmd_capture.sv
module cmd_capture (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  cmd_valid_i,
    input  logic                                  accept_i,
    input  i2c_cmd_pkg::frame_fmt_e               cmd_fmt_i,
    input  i2c_cmd_pkg::cmd_word_u                cmd_data_i,
    input  logic [i2c_cmd_pkg::BYTE_IDX_W-1:0]    byte_idx_i,
    output logic [i2c_cmd_pkg::BYTE_CNT_W-1:0]    byte_count_o,
    output logic [i2c_cmd_pkg::BYTE_W-1:0]        tx_byte_o
);

    i2c_cmd_pkg::cmd_word_u  word_q;
    i2c_cmd_pkg::frame_fmt_e fmt_q;
    logic                    load;

    assign load = cmd_valid_i && accept_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fmt_q  <= i2c_cmd_pkg::FMT_REG8;
            word_q <= '0;
        end else if (load) begin
            fmt_q  <= cmd_fmt_i;
            word_q <= cmd_data_i;
        end
    end

    assign byte_count_o = (fmt_q == i2c_cmd_pkg::FMT_REG16) ? i2c_cmd_pkg::BYTES_REG16
                                                            : i2c_cmd_pkg::BYTES_REG8;

    ////////////////////////////////////////////////////////////////////////////
    // Byte select from the device address onward
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        tx_byte_o = '0;
        if (fmt_q == i2c_cmd_pkg::FMT_REG16) begin
            case (byte_idx_i)
                2'd0:    tx_byte_o = word_q.reg16.dev_addr;
                2'd1:    tx_byte_o = word_q.reg16.reg_hi;
                2'd2:    tx_byte_o = word_q.reg16.reg_lo;
                default: tx_byte_o = word_q.reg16.wr_data;
            endcase
        end else begin
            // Bits 31..24 never reach the bus
            case (byte_idx_i)
                2'd0:    tx_byte_o = word_q.reg8.dev_addr;
                2'd1:    tx_byte_o = word_q.reg8.reg_addr;
                2'd2:    tx_byte_o = word_q.reg8.wr_data;
                default: tx_byte_o = '0;
            endcase
        end
    end

endmodule

// File: i2c_bit_driver.sv
module i2c_bit_driver (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              byte_go_i,
    input  logic [i2c_cmd_pkg::BYTE_W-1:0]    tx_byte_i,
    output logic                              scl_o,
    output logic                              sda_o,
    output logic                              sda_oe_o,
    output logic                              byte_last_phase_o
);

    localparam logic [i2c_cmd_pkg::PHASE_CNT_W-1:0] PHASE_LAST =
        i2c_cmd_pkg::PHASE_CNT_W'(i2c_cmd_pkg::PHASES_PER_BIT - 1);
    localparam logic [i2c_cmd_pkg::BIT_CNT_W-1:0] ACK_SLOT =
        i2c_cmd_pkg::BIT_CNT_W'(i2c_cmd_pkg::BITS_PER_BYTE_SLOT - 1);

    logic [i2c_cmd_pkg::BYTE_W-1:0]      shift_q;
    logic [i2c_cmd_pkg::PHASE_CNT_W-1:0] phase_q;
    logic [i2c_cmd_pkg::BIT_CNT_W-1:0]   bit_q;
    logic                                active_q;
    logic                                slot_end;
    logic                                ack_slot;

    assign slot_end = (phase_q == PHASE_LAST);
    assign ack_slot = (bit_q == ACK_SLOT);

    ////////////////////////////////////////////////////////////////////////////
    // Phase and bit counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active_q <= 1'b0;
            phase_q  <= '0;
            bit_q    <= '0;
        end else if (byte_go_i) begin
            // A new byte may load in the last phase of the previous one
            active_q <= 1'b1;
            phase_q  <= '0;
            bit_q    <= '0;
        end else if (active_q) begin
            if (slot_end) begin
                phase_q <= '0;
                if (ack_slot) begin
                    active_q <= 1'b0;
                end else begin
                    bit_q <= bit_q + 4'd1;
                end
            end else begin
                phase_q <= phase_q + 2'd1;
            end
        end
    end

    // MSB first with one shift per data slot
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            shift_q <= '0;
        end else if (byte_go_i) begin
            shift_q <= tx_byte_i;
        end else if (active_q && slot_end && !ack_slot) begin
            shift_q <= {shift_q[i2c_cmd_pkg::BYTE_W-2:0], 1'b0};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus levels
    ////////////////////////////////////////////////////////////////////////////

    // SCL low, high, low within each slot
    assign scl_o = active_q && (phase_q == i2c_cmd_pkg::SCL_HIGH_PHASE);

    assign sda_o = shift_q[i2c_cmd_pkg::BYTE_W-1];

    // Released for the slave's acknowledge
    assign sda_oe_o = !ack_slot;

    assign byte_last_phase_o = active_q && ack_slot && slot_end;

endmodule

// File: i2c_byte_sequencer.sv
module i2c_byte_sequencer (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  logic                                  cmd_valid_i,
    input  logic [i2c_cmd_pkg::BYTE_CNT_W-1:0]    byte_count_i,
    input  logic                                  byte_last_phase_i,
    output logic                                  accept_o,
    output logic                                  byte_go_o,
    output logic [i2c_cmd_pkg::BYTE_IDX_W-1:0]    byte_idx_o,
    input  logic                                  bit_scl_i,
    input  logic                                  bit_sda_i,
    input  logic                                  bit_sda_oe_i,
    output logic                                  scl_o,
    output logic                                  sda_o,
    output logic                                  sda_oe_o,
    output logic                                  busy_o,
    output logic                                  cmd_done_o
);

    localparam logic [i2c_cmd_pkg::STEP_CNT_W-1:0] START_LAST =
        i2c_cmd_pkg::STEP_CNT_W'(i2c_cmd_pkg::START_CYCLES - 1);
    localparam logic [i2c_cmd_pkg::STEP_CNT_W-1:0] STOP_LAST =
        i2c_cmd_pkg::STEP_CNT_W'(i2c_cmd_pkg::STOP_CYCLES - 1);

    logic [i2c_cmd_pkg::SEQ_ST_W-1:0]   state_q;
    logic [i2c_cmd_pkg::STEP_CNT_W-1:0] step_q;
    logic [i2c_cmd_pkg::BYTE_IDX_W-1:0] byte_idx_q;
    logic                               in_byte_slot;
    logic                               last_byte;
    logic                               own_scl;
    logic                               own_sda;

    assign in_byte_slot = (state_q == i2c_cmd_pkg::SEQ_BYTE);
    assign last_byte    = ({1'b0, byte_idx_q} == byte_count_i - 3'd1);

    assign accept_o = cmd_valid_i && (state_q == i2c_cmd_pkg::SEQ_IDLE);
    assign busy_o   = (state_q != i2c_cmd_pkg::SEQ_IDLE);

    // First byte leaves in the last start cycle, later ones chain off the ack slot
    assign byte_go_o = ((state_q == i2c_cmd_pkg::SEQ_START) && (step_q == START_LAST)) ||
                       (in_byte_slot && byte_last_phase_i && !last_byte);

    // Index of the byte loaded on byte_go_o
    assign byte_idx_o = in_byte_slot ? byte_idx_q + 2'd1 : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= i2c_cmd_pkg::SEQ_IDLE;
            step_q     <= '0;
            byte_idx_q <= '0;
        end else begin
            case (state_q)
                i2c_cmd_pkg::SEQ_IDLE: begin
                    if (accept_o) begin
                        state_q    <= i2c_cmd_pkg::SEQ_START;
                        step_q     <= '0;
                        byte_idx_q <= '0;
                    end
                end
                i2c_cmd_pkg::SEQ_START: begin
                    if (step_q == START_LAST) begin
                        state_q <= i2c_cmd_pkg::SEQ_BYTE;
                        step_q  <= '0;
                    end else begin
                        step_q <= step_q + 2'd1;
                    end
                end
                i2c_cmd_pkg::SEQ_BYTE: begin
                    if (byte_last_phase_i) begin
                        if (last_byte) begin
                            state_q <= i2c_cmd_pkg::SEQ_STOP;
                        end else begin
                            byte_idx_q <= byte_idx_q + 2'd1;
                        end
                    end
                end
                default: begin
                    if (step_q == STOP_LAST) begin
                        state_q <= i2c_cmd_pkg::SEQ_IDLE;
                        step_q  <= '0;
                    end else begin
                        step_q <= step_q + 2'd1;
                    end
                end
            endcase
        end
    end

    // Start is 11, 10, 00 and stop is 00, 10, 11 as (SCL, SDA)
    always_comb begin
        own_scl = 1'b1;
        own_sda = 1'b1;
        if (state_q == i2c_cmd_pkg::SEQ_START) begin
            own_scl = (step_q != START_LAST);
            own_sda = (step_q == '0);
        end else if (state_q == i2c_cmd_pkg::SEQ_STOP) begin
            own_scl = (step_q != '0);
            own_sda = (step_q == STOP_LAST);
        end
    end

    assign scl_o    = in_byte_slot ? bit_scl_i    : own_scl;
    assign sda_o    = in_byte_slot ? bit_sda_i    : own_sda;
    assign sda_oe_o = in_byte_slot ? bit_sda_oe_i : 1'b1;

    // SCL high with SDA still low, one cycle ahead of the stop edge
    assign cmd_done_o = (state_q == i2c_cmd_pkg::SEQ_STOP) && (step_q == 2'd1);

endmodule

// File: i2c_cmd_top.sv
module i2c_cmd_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       cmd_valid_i,
    input  i2c_cmd_pkg::frame_fmt_e    cmd_fmt_i,
    input  i2c_cmd_pkg::cmd_word_u     cmd_data_i,
    output logic                       busy_o,
    output logic                       cmd_done_o,
    output logic                       scl_o,
    output logic                       sda_o,
    output logic                       sda_oe_o
);

    logic                                  accept;
    logic                                  byte_go;
    logic                                  byte_last_phase;
    logic [i2c_cmd_pkg::BYTE_IDX_W-1:0]    byte_idx;
    logic [i2c_cmd_pkg::BYTE_CNT_W-1:0]    byte_count;
    logic [i2c_cmd_pkg::BYTE_W-1:0]        tx_byte;
    logic                                  bit_scl;
    logic                                  bit_sda;
    logic                                  bit_sda_oe;

    cmd_capture u_cmd_capture (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .accept_i     (accept),
        .cmd_fmt_i    (cmd_fmt_i),
        .cmd_data_i   (cmd_data_i),
        .byte_idx_i   (byte_idx),
        .byte_count_o (byte_count),
        .tx_byte_o    (tx_byte)
    );

    i2c_byte_sequencer u_i2c_byte_sequencer (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .cmd_valid_i       (cmd_valid_i),
        .byte_count_i      (byte_count),
        .byte_last_phase_i (byte_last_phase),
        .accept_o          (accept),
        .byte_go_o         (byte_go),
        .byte_idx_o        (byte_idx),
        .bit_scl_i         (bit_scl),
        .bit_sda_i         (bit_sda),
        .bit_sda_oe_i      (bit_sda_oe),
        .scl_o             (scl_o),
        .sda_o             (sda_o),
        .sda_oe_o          (sda_oe_o),
        .busy_o            (busy_o),
        .cmd_done_o        (cmd_done_o)
    );

    i2c_bit_driver u_i2c_bit_driver (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .byte_go_i         (byte_go),
        .tx_byte_i         (tx_byte),
        .scl_o             (bit_scl),
        .sda_o             (bit_sda),
        .sda_oe_o          (bit_sda_oe),
        .byte_last_phase_o (byte_last_phase)
    );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Reset held for 10 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #2 rst_n_o = 1'b1;
    end

endmodule

// File: tb_i2c_cmd_assertions.sv
module tb_i2c_cmd_assertions (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic busy_i,
    input  logic cmd_done_i,
    input  logic scl_i,
    input  logic sda_i,
    input  logic sda_oe_i
);

    localparam logic [3:0] ACK_RISE = 4'(i2c_cmd_pkg::BITS_PER_BYTE_SLOT - 1);

    logic       sda_bus;
    logic       scl_q;
    logic [3:0] rise_cnt_q;
    logic       byte_rise;
    logic       idle_fail  = 1'b0;
    logic       start_fail = 1'b0;
    logic       stop_fail  = 1'b0;
    logic       done_fail  = 1'b0;
    logic       tail_fail  = 1'b0;
    logic       end_fail   = 1'b0;
    logic       ack_fail   = 1'b0;
    logic       any_fail;

    // Pull-up on the open-drain line
    assign sda_bus   = sda_oe_i ? sda_i : 1'b1;
    assign byte_rise = busy_i && !cmd_done_i && scl_i && !scl_q;
    assign any_fail  = idle_fail || start_fail || stop_fail || done_fail ||
                       tail_fail || end_fail || ack_fail;

    // SCL rises already seen in the current byte
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scl_q      <= 1'b1;
            rise_cnt_q <= '0;
        end else begin
            scl_q <= scl_i;
            if (!busy_i) begin
                rise_cnt_q <= '0;
            end else if (byte_rise) begin
                rise_cnt_q <= (rise_cnt_q == ACK_RISE) ? 4'd0 : rise_cnt_q + 4'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus protocol
    ////////////////////////////////////////////////////////////////////////////

    a_idle: assert property (@(posedge clk_i)
        (!rst_n_i || !busy_i) |-> (scl_i && sda_bus && !cmd_done_i))
    else begin
        $error("Bus not idle while in reset or with busy_o low");
        idle_fail = 1'b1;
    end

    a_start: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (scl_i && $past(scl_i) && !sda_bus && $past(sda_bus)) |->
            (busy_i && $past(busy_i) && !$past(busy_i, 2)))
    else begin
        $error("SDA fell with SCL high outside the start condition");
        start_fail = 1'b1;
    end

    a_stop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (scl_i && $past(scl_i) && sda_bus && !$past(sda_bus)) |->
            (busy_i && $past(cmd_done_i)))
    else begin
        $error("SDA rose with SCL high outside the stop condition");
        stop_fail = 1'b1;
    end

    a_done_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_done_i |-> (busy_i && scl_i && !sda_bus))
    else begin
        $error("cmd_done_o high without SCL high and SDA low");
        done_fail = 1'b1;
    end

    // One cycle of done, then the stop cycle, then idle
    a_done_tail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(cmd_done_i) |-> (!cmd_done_i && busy_i && scl_i && sda_bus))
    else begin
        $error("Frame did not end with one stop cycle after cmd_done_o");
        tail_fail = 1'b1;
    end

    a_done_end: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(cmd_done_i, 2) |-> !busy_i)
    else begin
        $error("busy_o still high two cycles after cmd_done_o");
        end_fail = 1'b1;
    end

    a_ack_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        byte_rise |-> (sda_oe_i == (rise_cnt_q != ACK_RISE)))
    else begin
        $error("SDA released on a data bit or driven in an acknowledge slot");
        ack_fail = 1'b1;
    end

endmodule

bind i2c_cmd_top tb_i2c_cmd_assertions u_assertions (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .busy_i     (busy_o),
    .cmd_done_i (cmd_done_o),
    .scl_i      (scl_o),
    .sda_i      (sda_o),
    .sda_oe_i   (sda_oe_o)
);

// File: tb_i2c_cmd.sv
module tb_i2c_cmd;

    localparam int DRIVE_DELAY   = 2;
    localparam int BUSY_TIMEOUT  = 200;
    localparam int RESET_TIMEOUT = 20;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    cmd_valid_i;
    i2c_cmd_pkg::frame_fmt_e cmd_fmt_i;
    i2c_cmd_pkg::cmd_word_u  cmd_data_i;
    logic                    busy_o;
    logic                    cmd_done_o;
    logic                    scl_o;
    logic                    sda_o;
    logic                    sda_oe_o;
    logic                    sda_bus;

    int         seed;
    int         errors       = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    int         err_mark     = 0;
    logic       assert_mark  = 1'b0;

    // Monitor state
    logic [7:0] frame_bytes[$];
    logic [7:0] shift_byte  = '0;
    int         bit_pos     = 0;
    int         busy_count  = 0;
    int         frame_count = 0;
    logic       busy_prev   = 1'b0;
    logic       scl_prev    = 1'b1;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    i2c_cmd_top DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_fmt_i   (cmd_fmt_i),
        .cmd_data_i  (cmd_data_i),
        .busy_o      (busy_o),
        .cmd_done_o  (cmd_done_o),
        .scl_o       (scl_o),
        .sda_o       (sda_o),
        .sda_oe_o    (sda_oe_o)
    );

    assign sda_bus = sda_oe_o ? sda_o : 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Bus monitor sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (busy_o && !busy_prev) begin
            frame_bytes.delete();
            busy_count  = 1;
            bit_pos     = 0;
            frame_count = frame_count + 1;
        end else if (busy_o) begin
            busy_count = busy_count + 1;
        end
        // The stop edge comes with cmd_done_o and carries no bit
        if (busy_o && !cmd_done_o && scl_o && !scl_prev) begin
            if (bit_pos == i2c_cmd_pkg::BYTE_W) begin
                frame_bytes.push_back(shift_byte);
                bit_pos = 0;
            end else begin
                shift_byte = {shift_byte[6:0], sda_bus};
                bit_pos    = bit_pos + 1;
            end
        end
        busy_prev = busy_o;
        scl_prev  = scl_o;
    end

    task automatic step_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors = errors + 1;
    endtask

    task automatic check_value(input string sig, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("Mismatch %s: expected %0h, observed %0h", sig, exp, got);
            errors = errors + 1;
        end
    endtask

    task automatic open_test();
        err_mark    = errors;
        assert_mark = DUT.u_assertions.any_fail;
    endtask

    task automatic close_test(input string name);
        tests_run = tests_run + 1;
        if (errors != err_mark || (DUT.u_assertions.any_fail && !assert_mark)) begin
            tests_failed = tests_failed + 1;
            $display("Test %s: FAIL", name);
        end else begin
            $display("Test %s: PASS", name);
        end
    endtask

    // Sends one command and checks the frame that follows it
    task automatic send_frame(input i2c_cmd_pkg::frame_fmt_e fmt, input logic [31:0] word,
                              input bit inject);
        logic [7:0] exp_bytes[$];
        int         exp_len;
        int         frames_before;
        int         cycles;
        if (fmt == i2c_cmd_pkg::FMT_REG16) begin
            exp_bytes.push_back(word[31:24]);
        end
        exp_bytes.push_back(word[23:16]);
        exp_bytes.push_back(word[15:8]);
        exp_bytes.push_back(word[7:0]);
        exp_len = i2c_cmd_pkg::START_CYCLES + i2c_cmd_pkg::STOP_CYCLES +
                  exp_bytes.size() * i2c_cmd_pkg::BITS_PER_BYTE_SLOT *
                  i2c_cmd_pkg::PHASES_PER_BIT;
        frames_before = frame_count;
        cmd_valid_i   = 1'b1;
        cmd_fmt_i     = fmt;
        cmd_data_i    = word;
        step_cycle();
        cmd_valid_i = 1'b0;
        cycles      = 0;
        while (busy_o && cycles < BUSY_TIMEOUT) begin
            // Competing request in the middle of the frame
            if (inject && cycles == 10) begin
                cmd_valid_i = 1'b1;
                cmd_fmt_i   = i2c_cmd_pkg::frame_fmt_e'(~fmt);
                cmd_data_i  = ~word;
            end else begin
                cmd_valid_i = 1'b0;
            end
            step_cycle();
            cycles = cycles + 1;
        end
        if (busy_o) begin
            report_timeout("busy_o to fall");
        end else begin
            check_value("frame count", frames_before + 1, frame_count);
            check_value("busy_o cycles", exp_len, busy_count);
            check_value("byte count", exp_bytes.size(), frame_bytes.size());
            foreach (exp_bytes[i]) begin
                if (i < frame_bytes.size()) begin
                    check_value("sda_o byte", 32'(exp_bytes[i]), 32'(frame_bytes[i]));
                end
            end
        end
    endtask

    initial begin
        int          cycles;
        int          frames;
        logic [31:0] word;
        logic [31:0] rnd;
        seed        = 32'h5ce1_0577;
        cmd_valid_i = 1'b0;
        cmd_fmt_i   = i2c_cmd_pkg::FMT_REG8;
        cmd_data_i  = '0;

        open_test();
        cycles = 0;
        while (!rst_n_i && cycles < RESET_TIMEOUT) begin
            step_cycle();
            cycles = cycles + 1;
        end
        if (!rst_n_i) begin
            report_timeout("reset release");
        end else begin
            repeat (5) step_cycle();
            check_value("busy_o", 32'd0, 32'(busy_o));
        end
        close_test("reset_idle");

        open_test();
        send_frame(i2c_cmd_pkg::FMT_REG16, 32'h6c30_1a5e, 1'b0);
        close_test("write_reg16");

        open_test();
        send_frame(i2c_cmd_pkg::FMT_REG8, 32'hff21_07c4, 1'b0);
        close_test("write_reg8");

        // Request during busy_o must leave no trace
        open_test();
        send_frame(i2c_cmd_pkg::FMT_REG16, 32'h3c12_34a5, 1'b1);
        frames = frame_count;
        repeat (5) step_cycle();
        check_value("frame count", frames, frame_count);
        check_value("busy_o", 32'd0, 32'(busy_o));
        close_test("ignored_request");

        open_test();
        repeat (20) begin
            rnd  = $random(seed);
            word = $random(seed);
            send_frame(i2c_cmd_pkg::frame_fmt_e'(rnd[0]), word, 1'b0);
        end
        close_test("back_to_back");

        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !DUT.u_assertions.any_fail) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: sim.f
i2c_cmd_pkg.sv
cmd_capture.sv
i2c_bit_driver.sv
i2c_byte_sequencer.sv
i2c_cmd_top.sv
tb_clock_gen.sv
tb_i2c_cmd_assertions.sv
tb_i2c_cmd.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module tb_i2c_cmd -o tb_i2c_cmd_sim

# Keep running past assertion errors so the testbench can report them
./obj_dir/tb_i2c_cmd_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
